// ==== src/espi_pc_pkg.sv ====
`default_nettype none

package espi_pc_pkg;

    // one channel byte as delivered by the link layer
    localparam int BYTE_W = 8;

    // the receive queue depth must stay a power of two
    localparam int RX_DEPTH = 16;
    localparam int RX_PTR_W = 4;   // count registers are one bit wider

    // host bus
    localparam int APB_ADDR_W = 4;
    localparam int APB_DATA_W = 32;

    // register map in byte addresses of 32-bit words
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS  = 4'h0;  // read only
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL    = 4'h4;
    localparam logic [APB_ADDR_W-1:0] ADDR_PC_DATA = 4'h8;  // read pops the posted queue
    localparam logic [APB_ADDR_W-1:0] ADDR_NP_DATA = 4'hC;  // read pops the non-posted queue

    // status word layout
    localparam int STAT_PC_AVAIL = 0;
    localparam int STAT_NP_AVAIL = 1;
    localparam int STAT_PC_FREE  = 2;
    localparam int STAT_NP_FREE  = 3;
    localparam int STAT_PC_EMPTY = 4;
    localparam int STAT_NP_EMPTY = 5;

    // control word layout
    // the enable bit goes straight out as the channel-ready indication
    localparam int CTRL_CHAN_EN = 0;

endpackage

`default_nettype wire

// ==== src/rx_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_queue (
    input  logic                             clk,
    input  logic                             channel_reset_n,
    input  logic                             flush,
    input  logic                             put,
    input  logic [espi_pc_pkg::BYTE_W-1:0]   wdata,
    input  logic                             commit,
    input  logic                             commit_error,
    input  logic                             pop,
    output logic [espi_pc_pkg::BYTE_W-1:0]   rdata,
    output logic                             empty,
    output logic                             avail,
    output logic                             free
);

    logic [espi_pc_pkg::BYTE_W-1:0] mem [espi_pc_pkg::RX_DEPTH];
    logic [espi_pc_pkg::RX_PTR_W-1:0] wr_ptr;
    logic [espi_pc_pkg::RX_PTR_W-1:0] rd_ptr;
    logic [espi_pc_pkg::RX_PTR_W:0] count;
    logic full;
    logic do_put;
    logic do_pop;

    assign full  = (count == (espi_pc_pkg::RX_PTR_W+1)'(espi_pc_pkg::RX_DEPTH));
    assign empty = (count == '0);

    // a put into a full queue and a pop from an empty one are both ignored
    assign do_put = put && !full;
    assign do_pop = pop && !empty;

    // show-ahead read so the head byte is visible before it is popped
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_put) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge channel_reset_n) begin
        if (!channel_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_put) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (do_put && !do_pop) begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_put) begin
                count <= count - 1'b1;
            end
        end
    end

    // a packet is only offered to the host once its CRC end arrived clean
    always_ff @(posedge clk or negedge channel_reset_n) begin
        if (!channel_reset_n) begin
            avail <= 1'b0;
        end
        else begin
            if (commit && !commit_error) begin
                avail <= 1'b1;
            end
            else if (empty) begin
                avail <= 1'b0;   // drained or flushed
            end
        end
    end

    always_ff @(posedge clk or negedge channel_reset_n) begin
        if (!channel_reset_n) begin
            free <= 1'b1;        // queue comes out of reset empty
        end
        else begin
            if (empty) begin
                free <= 1'b1;
            end
            else if (avail) begin
                free <= 1'b0;    // a complete packet is waiting for the host
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/rx_host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_host_regs (
    input  logic                                 clk,
    input  logic                                 channel_reset_n,
    input  logic [espi_pc_pkg::APB_ADDR_W-1:0]   paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [espi_pc_pkg::APB_DATA_W-1:0]   pwdata,
    output logic [espi_pc_pkg::APB_DATA_W-1:0]   prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    input  logic [espi_pc_pkg::BYTE_W-1:0]       pc_rdata,
    input  logic                                 pc_empty,
    input  logic                                 pc_avail,
    input  logic                                 pc_free,
    output logic                                 pc_pop,
    input  logic [espi_pc_pkg::BYTE_W-1:0]       np_rdata,
    input  logic                                 np_empty,
    input  logic                                 np_avail,
    input  logic                                 np_free,
    output logic                                 np_pop,
    output logic                                 pc_channel_ready
);

    logic access;
    logic rd_en;
    logic wr_en;
    logic hit_status;
    logic hit_ctrl;
    logic hit_pc_data;
    logic hit_np_data;
    logic chan_en;
    logic [espi_pc_pkg::APB_DATA_W-1:0] status_word;
    logic [espi_pc_pkg::APB_DATA_W-1:0] ctrl_word;

    // no wait states so every transfer completes in its access cycle
    assign pready = 1'b1;

    assign access = psel && penable;
    assign rd_en  = access && !pwrite;
    assign wr_en  = access && pwrite;

    assign hit_status  = (paddr == espi_pc_pkg::ADDR_STATUS);
    assign hit_ctrl    = (paddr == espi_pc_pkg::ADDR_CTRL);
    assign hit_pc_data = (paddr == espi_pc_pkg::ADDR_PC_DATA);
    assign hit_np_data = (paddr == espi_pc_pkg::ADDR_NP_DATA);

    always_comb begin
        status_word = '0;
        status_word[espi_pc_pkg::STAT_PC_AVAIL] = pc_avail;
        status_word[espi_pc_pkg::STAT_NP_AVAIL] = np_avail;
        status_word[espi_pc_pkg::STAT_PC_FREE]  = pc_free;
        status_word[espi_pc_pkg::STAT_NP_FREE]  = np_free;
        status_word[espi_pc_pkg::STAT_PC_EMPTY] = pc_empty;
        status_word[espi_pc_pkg::STAT_NP_EMPTY] = np_empty;
    end

    always_comb begin
        ctrl_word = '0;
        ctrl_word[espi_pc_pkg::CTRL_CHAN_EN] = chan_en;
    end

    // the byte returned in the access cycle is the one popped on its edge
    assign pc_pop = rd_en && hit_pc_data && !pc_empty;
    assign np_pop = rd_en && hit_np_data && !np_empty;

    always_comb begin
        prdata = '0;
        if (rd_en) begin
            if (hit_status) begin
                prdata = status_word;
            end
            else if (hit_ctrl) begin
                prdata = ctrl_word;
            end
            else if (hit_pc_data && !pc_empty) begin
                prdata[espi_pc_pkg::BYTE_W-1:0] = pc_rdata;
            end
            else if (hit_np_data && !np_empty) begin
                prdata[espi_pc_pkg::BYTE_W-1:0] = np_rdata;
            end
        end
    end

    // only the control register accepts writes
    assign pslverr = access && (!(hit_status || hit_ctrl || hit_pc_data || hit_np_data) ||
                                (pwrite && !hit_ctrl));

    always_ff @(posedge clk or negedge channel_reset_n) begin
        if (!channel_reset_n) begin
            chan_en <= 1'b0;
        end
        else if (wr_en && hit_ctrl) begin
            chan_en <= pwdata[espi_pc_pkg::CTRL_CHAN_EN];
        end
    end

    assign pc_channel_ready = chan_en;

endmodule

`default_nettype wire

// ==== src/espi_pc_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module espi_pc_rx (
    input  logic                                 clk,
    input  logic                                 channel_reset_n,
    input  logic                                 pc_put,
    input  logic                                 np_put,
    input  logic [espi_pc_pkg::BYTE_W-1:0]       rx_byte,
    input  logic                                 pc_commit,
    input  logic                                 np_commit,
    input  logic                                 rx_error,
    input  logic                                 flush_pc_fifo,
    input  logic [espi_pc_pkg::APB_ADDR_W-1:0]   paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [espi_pc_pkg::APB_DATA_W-1:0]   pwdata,
    output logic [espi_pc_pkg::APB_DATA_W-1:0]   prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic                                 pc_channel_ready
);

    logic [espi_pc_pkg::BYTE_W-1:0] pc_rdata;
    logic [espi_pc_pkg::BYTE_W-1:0] np_rdata;
    logic pc_empty;
    logic pc_avail;
    logic pc_free;
    logic pc_pop;
    logic np_empty;
    logic np_avail;
    logic np_free;
    logic np_pop;

    // the link layer steers each byte and both queues share the byte bus
    rx_queue u_pc_queue (
        .clk             (clk),
        .channel_reset_n (channel_reset_n),
        .flush           (flush_pc_fifo),
        .put             (pc_put),
        .wdata           (rx_byte),
        .commit          (pc_commit),
        .commit_error    (rx_error),
        .pop             (pc_pop),
        .rdata           (pc_rdata),
        .empty           (pc_empty),
        .avail           (pc_avail),
        .free            (pc_free)
    );

    rx_queue u_np_queue (
        .clk             (clk),
        .channel_reset_n (channel_reset_n),
        .flush           (flush_pc_fifo),   // one flush empties both queues
        .put             (np_put),
        .wdata           (rx_byte),
        .commit          (np_commit),
        .commit_error    (rx_error),
        .pop             (np_pop),
        .rdata           (np_rdata),
        .empty           (np_empty),
        .avail           (np_avail),
        .free            (np_free)
    );

    rx_host_regs u_regs (
        .clk              (clk),
        .channel_reset_n  (channel_reset_n),
        .paddr            (paddr),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .pc_rdata         (pc_rdata),
        .pc_empty         (pc_empty),
        .pc_avail         (pc_avail),
        .pc_free          (pc_free),
        .pc_pop           (pc_pop),
        .np_rdata         (np_rdata),
        .np_empty         (np_empty),
        .np_avail         (np_avail),
        .np_free          (np_free),
        .np_pop           (np_pop),
        .pc_channel_ready (pc_channel_ready)
    );

endmodule

`default_nettype wire

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

endmodule

`default_nettype wire

// ==== dv/espi_pc_rx_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module espi_pc_rx_asserts (
    input logic clk,
    input logic channel_reset_n,
    input logic psel,
    input logic penable,
    input logic pslverr,
    input logic pc_pop,
    input logic pc_empty,
    input logic np_pop,
    input logic np_empty
);

    penable_needs_psel: assert property (@(posedge clk) disable iff (!channel_reset_n)
        penable |-> psel) else $error("penable high without psel");

    // an error response only belongs to the access phase
    pslverr_in_access: assert property (@(posedge clk) disable iff (!channel_reset_n)
        pslverr |-> (psel && penable)) else $error("pslverr outside an access cycle");

    pc_pop_not_empty: assert property (@(posedge clk) disable iff (!channel_reset_n)
        pc_pop |-> !pc_empty) else $error("pop from the empty posted queue");

    np_pop_not_empty: assert property (@(posedge clk) disable iff (!channel_reset_n)
        np_pop |-> !np_empty) else $error("pop from the empty non-posted queue");

endmodule

bind espi_pc_rx espi_pc_rx_asserts u_asserts (
    .clk             (clk),
    .channel_reset_n (channel_reset_n),
    .psel            (psel),
    .penable         (penable),
    .pslverr         (pslverr),
    .pc_pop          (pc_pop),
    .pc_empty        (pc_empty),
    .np_pop          (np_pop),
    .np_empty        (np_empty)
);

`default_nettype wire

// ==== dv/tb_espi_pc_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_espi_pc_rx;

    localparam int VEC_WORDS   = 256;   // four words per operation
    localparam int READY_LIMIT = 8;

    logic        clk;
    logic        channel_reset_n;
    logic        pc_put;
    logic        np_put;
    logic [7:0]  rx_byte;
    logic        pc_commit;
    logic        np_commit;
    logic        rx_error;
    logic        flush_pc_fifo;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        pc_channel_ready;

    logic [31:0] vec [VEC_WORDS];
    int errors;
    int timeouts;

    clk_gen u_clk_gen (.clk(clk));

    espi_pc_rx dut (.*);

    function automatic string reg_name(input logic [3:0] addr);
        case (addr)
            espi_pc_pkg::ADDR_STATUS:  return "status";
            espi_pc_pkg::ADDR_CTRL:    return "ctrl";
            espi_pc_pkg::ADDR_PC_DATA: return "pc data";
            espi_pc_pkg::ADDR_NP_DATA: return "np data";
            default:                   return "unmapped";
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    // each link strobe is held for exactly one cycle
    task automatic put_byte(input logic to_np, input logic [7:0] b);
        @(posedge clk);
        pc_put  <= !to_np;
        np_put  <= to_np;
        rx_byte <= b;
        @(posedge clk);
        pc_put <= 1'b0;
        np_put <= 1'b0;
    endtask

    task automatic commit_packet(input logic to_np, input logic with_error);
        @(posedge clk);
        pc_commit <= !to_np;
        np_commit <= to_np;
        rx_error  <= with_error;
        @(posedge clk);
        pc_commit <= 1'b0;
        np_commit <= 1'b0;
        rx_error  <= 1'b0;
    endtask

    task automatic flush_queues();
        @(posedge clk);
        flush_pc_fifo <= 1'b1;
        @(posedge clk);
        flush_pc_fifo <= 1'b0;
    endtask

    // setup and access phase with the response sampled mid access cycle
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        waited = 0;
        while (pready !== 1'b1 && waited < READY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pready !== 1'b1) begin
            $display("timeout: no pready within %0d cycles at address 0x%h", READY_LIMIT, addr);
            timeouts++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        logic [31:0] got;
        logic        got_err;
        apb_access(1'b0, addr, 32'h0, got, got_err);
        check_value($sformatf("read of %s data", reg_name(addr)), got, exp_data);
        check_value($sformatf("read of %s pslverr", reg_name(addr)), {31'b0, got_err},
                    {31'b0, exp_err});
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata,
                             input logic exp_err);
        logic [31:0] unused_rdata;
        logic        got_err;
        apb_access(1'b1, addr, wdata, unused_rdata, got_err);
        check_value($sformatf("write to %s pslverr", reg_name(addr)), {31'b0, got_err},
                    {31'b0, exp_err});
    endtask

    task automatic check_ready(input logic exp);
        @(negedge clk);
        check_value("pc_channel_ready", {31'b0, pc_channel_ready}, {31'b0, exp});
    endtask

    // operation codes are listed at the top of the vector file
    task automatic run_op(input logic [31:0] op, input logic [31:0] arg,
                          input logic [31:0] data, input logic [31:0] err);
        int n;
        case (op[3:0])
            4'h1: put_byte(1'b0, data[7:0]);
            4'h2: put_byte(1'b1, data[7:0]);
            4'h3: commit_packet(1'b0, arg[0]);
            4'h4: commit_packet(1'b1, arg[0]);
            4'h5: flush_queues();
            4'h6: apb_write(arg[3:0], data, err[0]);
            4'h7: apb_read(arg[3:0], data, err[0]);
            4'h8: check_ready(data[0]);
            4'h9: repeat (data) @(posedge clk);
            4'ha: begin
                for (n = 0; n < arg; n++) begin
                    put_byte(1'b0, data[7:0] + n[7:0]);
                end
            end
            4'hb: begin
                for (n = 0; n < arg; n++) begin
                    apb_read(espi_pc_pkg::ADDR_PC_DATA, data + n, 1'b0);   // bytes count up
                end
            end
            default: begin
                $display("unknown operation code %0h in the vector file", op);
                errors++;
            end
        endcase
    endtask

    initial begin
        int idx;
        int seed_draw;
        channel_reset_n = 1'b0;
        pc_put          = 1'b0;
        np_put          = 1'b0;
        rx_byte         = 8'h00;
        pc_commit       = 1'b0;
        np_commit       = 1'b0;
        rx_error        = 1'b0;
        flush_pc_fifo   = 1'b0;
        paddr           = 4'h0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        pwdata          = 32'h0;
        errors          = 0;
        timeouts        = 0;
        seed_draw = $urandom(32'ha7c1);
        $readmemh("dv/espi_pc_rx_vectors.txt", vec);

        repeat (10) @(posedge clk);
        channel_reset_n <= 1'b1;

        for (idx = 0; idx + 3 < VEC_WORDS; idx += 4) begin
            if ($isunknown(vec[idx])) begin
                $display("vector file missing or without end marker at operation %0d", idx / 4);
                errors++;
                break;
            end
            if (vec[idx] == 32'hf) begin
                break;
            end
            run_op(vec[idx], vec[idx+1], vec[idx+2], vec[idx+3]);
            if (timeouts != 0) begin
                break;
            end
            repeat ($urandom % 4) @(posedge clk);   // idle gap between operations
        end

        $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end
        else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/espi_pc_rx_vectors.txt ====
// columns: op arg data err, all hex. op 1/2 put posted/non-posted byte (data),
// 3/4 commit posted/non-posted (arg = rx_error), 5 flush, 6 write / 7 read (arg = address,
// data = write data or expected read data, err = expected pslverr), 8 expect channel ready
// = data, 9 idle data cycles, a put arg posted bytes from data up, b read arg bytes, f end
8 0 00000000 0  // ready low out of reset
7 0 0000003c 0  // both queues empty and free
7 8 00000000 0  // empty posted queue reads 0
1 0 000000a5 0
1 0 0000005a 0
3 1 00000000 0  // commit with error keeps avail low
9 0 00000002 0
7 0 0000002c 0
3 0 00000000 0  // clean commit sets avail
9 0 00000002 0
7 0 00000029 0
7 8 000000a5 0
7 8 0000005a 0
9 0 00000002 0
7 0 0000003c 0  // avail cleared after drain
1 0 00000077 0
2 0 00000011 0
4 0 00000000 0
9 0 00000002 0
7 0 00000006 0  // non-posted avail, posted still free
7 c 00000011 0
7 8 00000077 0
9 0 00000002 0
7 0 0000003c 0
1 0 00000001 0
2 0 00000002 0
5 0 00000000 0  // flush empties both queues
9 0 00000002 0
7 0 0000003c 0
a 11 00000030 0 // seventeen puts, the last is dropped
3 0 00000000 0
b 10 00000030 0
7 8 00000000 0
6 4 00000001 0  // enable the channel
8 0 00000001 0
7 4 00000001 0
6 0 000000ff 1  // status is read only
6 c 00000000 1
7 2 00000000 1  // unmapped address
6 4 00000000 0
8 0 00000000 0
f 0 00000000 0

// ==== espi_pc_rx.f ====
src/espi_pc_pkg.sv
src/rx_queue.sv
src/rx_host_regs.sv
src/espi_pc_rx.sv
dv/clk_gen.sv
dv/espi_pc_rx_asserts.sv
dv/tb_espi_pc_rx.sv

// ==== Bender.yml ====
package:
  name: espi_pc_rx

sources:
  - src/espi_pc_pkg.sv
  - src/rx_queue.sv
  - src/rx_host_regs.sv
  - src/espi_pc_rx.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/espi_pc_rx_asserts.sv
      - dv/tb_espi_pc_rx.sv
